// ==== Bender.yml ====
package:
  name: i2c_wr

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/i2c_wr_reg_pkg.sv
      - source/i2c_wr_bus_pkg.sv
      - source/i2c_wr_regs.sv
      - source/i2c_wr_fifo.sv
      - source/i2c_wr_engine.sv
      - source/i2c_wr_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - sim/tb_i2c_wr.sv

// ==== flist.f ====
+incdir+source
source/i2c_wr_reg_pkg.sv
source/i2c_wr_bus_pkg.sv
source/i2c_wr_regs.sv
source/i2c_wr_fifo.sv
source/i2c_wr_engine.sv
source/i2c_wr_top.sv
sim/tb_i2c_wr.sv

// ==== sim/tb_i2c_wr.sv ====
/* testbench for the write-only I2C master, runs register sequences
   from a table against an I2C slave model that ACKs address 0x2A */
`include "i2c_wr_defs.svh"

module tb_i2c_wr;

    localparam int PRESC = 3;
    localparam int DEPTH = `I2C_WR_FIFO_DEPTH;

    typedef struct packed {
        logic [6:0] addr;
        logic       wr;
        logic       fs;
        logic       stop;
        logic [1:0] starts;
        logic [1:0] stops;
    } row_t;

    logic                      clk;
    logic                      rst;
    logic                      wr_en_i;
    logic                      rd_en_i;
    i2c_wr_reg_pkg::reg_addr_e addr_i;
    logic [31:0]               wdata_i;
    logic [1:0]                be_i;
    logic                      sda_i;
    logic [31:0]               rdata_o;
    logic                      scl_o;
    logic                      sda_o;

    // slave model
    logic       slave_sda = 1'b1;
    logic       scl_q = 1'b1;
    logic       sda_q = 1'b1;
    logic       addr_phase;
    logic       addressed;
    logic [3:0] bit_cnt;
    logic [7:0] shreg;
    logic [7:0] addr_log;
    int         starts;
    int         stops;
    int         hi_cnt;
    int         last_high;
    logic [7:0] data_log [$];

    logic [15:0] lfsr_q = 16'd68;
    logic [7:0]  exp_q [$];
    int          checks = 0;
    int          errors = 0;
    int          s0;
    int          p0;
    logic        held;

    // addr, write, force start, stop, expected starts, expected stops
    row_t rows [8] = '{
        '{7'h2A, 1'b1, 1'b0, 1'b0, 2'd1, 2'd0},
        '{7'h2A, 1'b1, 1'b0, 1'b0, 2'd0, 2'd0},
        '{7'h33, 1'b1, 1'b0, 1'b0, 2'd1, 2'd0},
        '{7'h2A, 1'b1, 1'b0, 1'b0, 2'd1, 2'd0},
        '{7'h2A, 1'b1, 1'b1, 1'b0, 2'd1, 2'd0},
        '{7'h2A, 1'b1, 1'b0, 1'b0, 2'd0, 2'd0},
        '{7'h2A, 1'b0, 1'b0, 1'b1, 2'd0, 2'd1},
        '{7'h2A, 1'b0, 1'b0, 1'b1, 2'd0, 2'd0}
    };

    i2c_wr_top u_dut (
        .clk(clk), .rst(rst), .wr_en_i(wr_en_i), .rd_en_i(rd_en_i), .addr_i(addr_i),
        .wdata_i(wdata_i), .be_i(be_i), .sda_i(sda_i), .rdata_o(rdata_o),
        .scl_o(scl_o), .sda_o(sda_o)
    );

    // open-drain line where either side pulls low
    assign sda_i = sda_o & slave_sda;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        scl_q  <= scl_o;
        sda_q  <= sda_i;
        hi_cnt <= scl_o ? (scl_q ? hi_cnt + 1 : 1) : 0;
        if (rst) begin
            slave_sda  <= 1'b1;
            bit_cnt    <= 4'd0;
            starts     <= 0;
            stops      <= 0;
            hi_cnt     <= 0;
            addr_phase <= 1'b0;
            addressed  <= 1'b0;
        end else if (scl_o && scl_q && sda_q && !sda_i) begin
            // start is sda falling while scl is high
            starts     <= starts + 1;
            bit_cnt    <= 4'd0;
            addr_phase <= 1'b1;
        end else if (scl_o && scl_q && !sda_q && sda_i) begin
            stops   <= stops + 1;
            bit_cnt <= 4'd0;
        end else if (scl_o && !scl_q) begin
            shreg   <= {shreg[6:0], sda_i};
            bit_cnt <= bit_cnt + 4'd1;
        end else if (!scl_o && scl_q) begin
            last_high <= hi_cnt;
            if ((bit_cnt == 4'd8) && addr_phase) begin
                addr_log   <= shreg;
                addressed  <= (shreg[7:1] == 7'h2A);
                slave_sda  <= (shreg[7:1] != 7'h2A);
                addr_phase <= 1'b0;
            end else if (bit_cnt == 4'd8) begin
                data_log.push_back(shreg);
                slave_sda <= !addressed;
            end else if (bit_cnt == 4'd9) begin
                // let go of sda once the ack bit is over
                slave_sda <= 1'b1;
                bit_cnt   <= 4'd0;
            end
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic next_byte(output logic [7:0] b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            b = {b[6:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [31:0] cmd_word(input logic [6:0] a, input logic wr,
                                             input logic st, input logic fs);
        logic [31:0] w;
        w = '0;
        w[6:0] = a;
        w[`I2C_WR_CMD_WRITE] = wr;
        w[`I2C_WR_CMD_STOP]  = st;
        w[`I2C_WR_CMD_START] = fs;
        return w;
    endfunction

    task automatic end_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic reg_write(input i2c_wr_reg_pkg::reg_addr_e a, input logic [31:0] d,
                             input logic [1:0] be);
        @(posedge clk);
        wr_en_i <= 1'b1;
        addr_i  <= a;
        wdata_i <= d;
        be_i    <= be;
        @(posedge clk);
        wr_en_i <= 1'b0;
    endtask

    task automatic reg_read(input i2c_wr_reg_pkg::reg_addr_e a, output logic [31:0] d);
        @(posedge clk);
        rd_en_i <= 1'b1;
        addr_i  <= a;
        @(posedge clk);
        rd_en_i <= 1'b0;
        @(negedge clk);
        d = rdata_o;
    endtask

    // poll busy until the command completes
    task automatic wait_idle();
        logic [31:0] st;
        int          polls;
        polls = 0;
        reg_read(i2c_wr_reg_pkg::STATUS, st);
        while (st[`I2C_WR_ST_BUSY] && (polls < 3000)) begin
            reg_read(i2c_wr_reg_pkg::STATUS, st);
            polls++;
        end
        if (st[`I2C_WR_ST_BUSY]) begin
            errors++;
            $display("timeout: busy still set after %0d status polls", polls);
            end_run();
        end
    endtask

    task automatic check_status(input logic bc, input logic ma, input logic co,
                                input logic em, input logic fu, input logic ov);
        logic [31:0] st;
        logic [31:0] exp;
        exp = '0;
        exp[`I2C_WR_ST_BUS_CONT] = bc;
        exp[`I2C_WR_ST_MISS_ACK] = ma;
        exp[`I2C_WR_ST_CMD_OVF]  = co;
        exp[`I2C_WR_ST_WR_EMPTY] = em;
        exp[`I2C_WR_ST_WR_FULL]  = fu;
        exp[`I2C_WR_ST_WR_OVF]   = ov;
        reg_read(i2c_wr_reg_pkg::STATUS, st);
        check_eq("status", st, exp);
    endtask

    task automatic mark_events();
        s0 = starts;
        p0 = stops;
    endtask

    task automatic check_events(input int es, input int ep);
        check_eq("start count", starts - s0, es);
        check_eq("stop count", stops - p0, ep);
    endtask

    // bytes seen by the slave against bytes pushed in order
    task automatic check_bytes();
        logic [7:0] got;
        logic [7:0] exp;
        while ((exp_q.size() > 0) && (data_log.size() > 0)) begin
            got = data_log.pop_front();
            exp = exp_q.pop_front();
            check_eq("data byte", got, exp);
        end
        checks++;
        assert ((exp_q.size() == 0) && (data_log.size() == 0)) else begin
            errors++;
            $display("bus carried %0d bytes too many and missed %0d expected bytes",
                     data_log.size(), exp_q.size());
            data_log.delete();
            exp_q.delete();
        end
    endtask

    initial begin : main
        logic [31:0] rd;
        logic [7:0]  b;
        logic [7:0]  b_left;
        rst     = 1'b1;
        wr_en_i = 1'b0;
        rd_en_i = 1'b0;
        addr_i  = i2c_wr_reg_pkg::STATUS;
        wdata_i = '0;
        be_i    = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // reset values
        check_status(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        reg_read(i2c_wr_reg_pkg::PRESCALE, rd);
        check_eq("prescale", rd, `I2C_WR_DEFAULT_PRESCALE);
        @(negedge clk);
        check_eq("scl_o", scl_o, 1'b1);
        check_eq("sda_o", sda_o, 1'b1);

        // prescale read back on both bytes
        reg_write(i2c_wr_reg_pkg::PRESCALE, 32'h0000A503, 2'b11);
        reg_read(i2c_wr_reg_pkg::PRESCALE, rd);
        check_eq("prescale", rd, 32'h0000A503);
        reg_write(i2c_wr_reg_pkg::PRESCALE, PRESC, 2'b11);
        reg_read(i2c_wr_reg_pkg::PRESCALE, rd);
        check_eq("prescale", rd, PRESC);

        // single write with stop
        mark_events();
        next_byte(b);
        reg_write(i2c_wr_reg_pkg::DATA, {24'd0, b}, 2'b01);
        exp_q.push_back(b);
        reg_write(i2c_wr_reg_pkg::COMMAND, cmd_word(7'h2A, 1'b1, 1'b1, 1'b0), 2'b11);
        wait_idle();
        check_events(1, 1);
        check_eq("address byte", addr_log, {7'h2A, 1'b0});
        check_bytes();
        check_eq("scl high cycles", last_high, 2 * (PRESC + 1));
        check_status(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        // stored command fields read back
        reg_read(i2c_wr_reg_pkg::COMMAND, rd);
        check_eq("command", rd, cmd_word(7'h2A, 1'b1, 1'b1, 1'b0));

        held = 1'b0;
        for (int i = 0; i < 8; i++) begin
            mark_events();
            if (rows[i].wr) begin
                next_byte(b);
                reg_write(i2c_wr_reg_pkg::DATA, {24'd0, b}, 2'b01);
                exp_q.push_back(b);
            end
            reg_write(i2c_wr_reg_pkg::COMMAND,
                      cmd_word(rows[i].addr, rows[i].wr, rows[i].stop, rows[i].fs), 2'b11);
            wait_idle();
            check_events(rows[i].starts, rows[i].stops);
            check_bytes();
            if (rows[i].stop) begin
                held = 1'b0;
            end else if (rows[i].wr) begin
                held = 1'b1;
            end
            reg_read(i2c_wr_reg_pkg::STATUS, rd);
            check_eq("bus_control", rd[`I2C_WR_ST_BUS_CONT], held);
        end
        // address 0x33 went unanswered
        check_status(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
        reg_write(i2c_wr_reg_pkg::STATUS, 32'd1 << `I2C_WR_ST_MISS_ACK, 2'b01);
        check_status(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);

        // missed ack plus a command dropped while busy
        mark_events();
        next_byte(b);
        reg_write(i2c_wr_reg_pkg::DATA, {24'd0, b}, 2'b01);
        exp_q.push_back(b);
        next_byte(b_left);
        reg_write(i2c_wr_reg_pkg::DATA, {24'd0, b_left}, 2'b01);
        reg_write(i2c_wr_reg_pkg::COMMAND, cmd_word(7'h11, 1'b1, 1'b1, 1'b0), 2'b11);
        reg_write(i2c_wr_reg_pkg::COMMAND, cmd_word(7'h2A, 1'b1, 1'b1, 1'b0), 2'b11);
        wait_idle();
        check_events(1, 1);
        check_bytes();
        check_status(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        reg_write(i2c_wr_reg_pkg::STATUS, 32'd1 << `I2C_WR_ST_MISS_ACK, 2'b01);
        check_status(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        reg_write(i2c_wr_reg_pkg::STATUS, 32'd1 << `I2C_WR_ST_CMD_OVF, 2'b10);
        check_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        // leftover byte drains with the next command
        exp_q.push_back(b_left);
        reg_write(i2c_wr_reg_pkg::COMMAND, cmd_word(7'h2A, 1'b1, 1'b1, 1'b0), 2'b11);
        wait_idle();
        check_bytes();

        // one push past full is lost
        mark_events();
        for (int i = 0; i <= DEPTH; i++) begin
            next_byte(b);
            reg_write(i2c_wr_reg_pkg::DATA, {24'd0, b}, 2'b01);
            if (i < DEPTH) begin
                exp_q.push_back(b);
            end
        end
        check_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
        reg_write(i2c_wr_reg_pkg::STATUS, 32'd1 << `I2C_WR_ST_WR_OVF, 2'b10);
        check_status(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        for (int i = 0; i < DEPTH; i++) begin
            reg_write(i2c_wr_reg_pkg::COMMAND,
                      cmd_word(7'h2A, 1'b1, (i == DEPTH - 1), 1'b0), 2'b11);
            wait_idle();
        end
        check_events(1, 1);
        check_bytes();
        check_status(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);

        end_run();
    end

endmodule

// ==== source/i2c_wr_bus_pkg.sv ====
/* bus-side types: engine sequencer states and the
   four quarter periods that make up one SCL bit */
package i2c_wr_bus_pkg;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        START     = 3'd1,
        ADDR      = 3'd2,
        DATA      = 3'd3,
        ACK       = 3'd4,
        STOP      = 3'd5,
        WAIT_DATA = 3'd6
    } eng_state_e;

    // scl low in Q0 and Q3, high in Q1 and Q2
    typedef enum logic [1:0] {
        Q0 = 2'd0,
        Q1 = 2'd1,
        Q2 = 2'd2,
        Q3 = 2'd3
    } phase_e;

endpackage

// ==== source/i2c_wr_defs.svh ====
/* shared constants for the write-only I2C master
   widths, FIFO depth, reset prescale and register bit positions */
`ifndef I2C_WR_DEFS_SVH
`define I2C_WR_DEFS_SVH

// byte and device address widths
`define I2C_WR_DATA_W 8
`define I2C_WR_ADDR_W 7

`define I2C_WR_FIFO_DEPTH 8
`define I2C_WR_DEFAULT_PRESCALE 2
// word address, byte offsets 0x0 to 0xC
`define I2C_WR_REG_AW 2

// status word bits
`define I2C_WR_ST_BUSY 0
`define I2C_WR_ST_BUS_CONT 1
`define I2C_WR_ST_MISS_ACK 3
`define I2C_WR_ST_CMD_OVF 10
`define I2C_WR_ST_WR_EMPTY 11
`define I2C_WR_ST_WR_FULL 12
`define I2C_WR_ST_WR_OVF 13

// command word bits, address sits in [6:0]
`define I2C_WR_CMD_START 8
`define I2C_WR_CMD_WRITE 10
`define I2C_WR_CMD_STOP 12

`endif

// ==== source/i2c_wr_engine.sv ====
/* I2C write sequencer: start, address, data byte, ACK check, stop
   one SCL bit is four quarters of prescale+1 clocks, open-drain outputs */
`include "i2c_wr_defs.svh"

module i2c_wr_engine (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cmd_valid_i,
    input  i2c_wr_reg_pkg::cmd_op_e       cmd_op_i,
    input  logic [`I2C_WR_ADDR_W-1:0]     cmd_addr_i,
    input  logic                          cmd_start_i,
    input  logic [15:0]                   prescale_i,
    input  logic                          fifo_empty_i,
    input  logic [`I2C_WR_DATA_W-1:0]     fifo_data_i,
    input  logic                          sda_i,
    output logic                          fifo_pop_o,
    output logic                          busy_o,
    output logic                          bus_control_o,
    output logic                          missed_ack_o,
    output logic                          scl_o,
    output logic                          sda_o
);

    i2c_wr_bus_pkg::eng_state_e       state_q;
    i2c_wr_bus_pkg::phase_e           phase_q;
    i2c_wr_reg_pkg::cmd_op_e          op_q;
    logic [15:0]                      qcnt_q;
    logic [2:0]                       bit_q;
    logic [`I2C_WR_DATA_W-1:0]        shift_q;
    logic [`I2C_WR_DATA_W-1:0]        data_q;
    logic [`I2C_WR_ADDR_W-1:0]        held_addr_q;
    logic                             start_q;
    logic                             data_byte_q;
    logic                             running;
    logic                             tick;
    logic                             bit_end;
    logic                             scl_d;
    logic                             sda_d;

    // quarter counter only runs while the bus is being clocked
    assign running = (state_q != i2c_wr_bus_pkg::IDLE) && (state_q != i2c_wr_bus_pkg::WAIT_DATA);
    assign tick    = (qcnt_q == 16'd0);
    assign bit_end = tick && (phase_q == i2c_wr_bus_pkg::Q3);

    // line levels per state and quarter
    always_comb begin
        scl_d = 1'b1;
        sda_d = 1'b1;
        case (state_q)
            i2c_wr_bus_pkg::START: begin
                // Q0 keeps scl where it was, sda falls in Q2 with scl high
                scl_d = (phase_q == i2c_wr_bus_pkg::Q0) ? !bus_control_o
                                                       : (phase_q != i2c_wr_bus_pkg::Q3);
                sda_d = (phase_q == i2c_wr_bus_pkg::Q0) || (phase_q == i2c_wr_bus_pkg::Q1);
            end
            i2c_wr_bus_pkg::ADDR, i2c_wr_bus_pkg::DATA: begin
                scl_d = (phase_q == i2c_wr_bus_pkg::Q1) || (phase_q == i2c_wr_bus_pkg::Q2);
                sda_d = shift_q[`I2C_WR_DATA_W-1];
            end
            i2c_wr_bus_pkg::ACK: begin
                scl_d = (phase_q == i2c_wr_bus_pkg::Q1) || (phase_q == i2c_wr_bus_pkg::Q2);
            end
            i2c_wr_bus_pkg::STOP: begin
                // sda rises in Q2 with scl high
                scl_d = (phase_q != i2c_wr_bus_pkg::Q0);
                sda_d = (phase_q == i2c_wr_bus_pkg::Q2) || (phase_q == i2c_wr_bus_pkg::Q3);
            end
            default: begin
                // held bus parks scl low
                scl_d = !bus_control_o;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q       <= i2c_wr_bus_pkg::IDLE;
            phase_q       <= i2c_wr_bus_pkg::Q0;
            op_q          <= i2c_wr_reg_pkg::OP_NONE;
            qcnt_q        <= '0;
            bit_q         <= '0;
            held_addr_q   <= '0;
            start_q       <= 1'b0;
            data_byte_q   <= 1'b0;
            fifo_pop_o    <= 1'b0;
            busy_o        <= 1'b0;
            bus_control_o <= 1'b0;
            missed_ack_o  <= 1'b0;
            scl_o         <= 1'b1;
            sda_o         <= 1'b1;
        end else begin
            scl_o        <= scl_d;
            sda_o        <= sda_d;
            fifo_pop_o   <= 1'b0;
            missed_ack_o <= 1'b0;
            if (!running) begin
                qcnt_q  <= prescale_i;
                phase_q <= i2c_wr_bus_pkg::Q0;
            end else if (tick) begin
                qcnt_q  <= prescale_i;
                phase_q <= i2c_wr_bus_pkg::phase_e'(phase_q + 2'd1);
            end else begin
                qcnt_q <= qcnt_q - 16'd1;
            end
            case (state_q)
                i2c_wr_bus_pkg::IDLE: begin
                    // busy drops one cycle after returning here
                    busy_o <= cmd_valid_i;
                    if (cmd_valid_i) begin
                        op_q <= cmd_op_i;
                        if (cmd_op_i == i2c_wr_reg_pkg::OP_STOP) begin
                            // stop with the bus released needs no bus activity
                            if (bus_control_o) begin
                                state_q <= i2c_wr_bus_pkg::STOP;
                            end
                        end else if (cmd_op_i != i2c_wr_reg_pkg::OP_NONE) begin
                            start_q <= cmd_start_i || !bus_control_o ||
                                       (cmd_addr_i != held_addr_q);
                            held_addr_q <= cmd_addr_i;
                            state_q     <= i2c_wr_bus_pkg::WAIT_DATA;
                        end
                    end
                end
                i2c_wr_bus_pkg::WAIT_DATA: begin
                    if (!fifo_empty_i) begin
                        fifo_pop_o  <= 1'b1;
                        data_byte_q <= !start_q;
                        if (start_q) begin
                            state_q <= i2c_wr_bus_pkg::START;
                        end else begin
                            state_q <= i2c_wr_bus_pkg::DATA;
                        end
                    end
                end
                i2c_wr_bus_pkg::START: begin
                    if (bit_end) begin
                        bus_control_o <= 1'b1;
                        state_q       <= i2c_wr_bus_pkg::ADDR;
                    end
                end
                i2c_wr_bus_pkg::ADDR, i2c_wr_bus_pkg::DATA: begin
                    if (bit_end) begin
                        bit_q <= bit_q + 3'd1;
                        if (bit_q == 3'd7) begin
                            state_q <= i2c_wr_bus_pkg::ACK;
                        end
                    end
                end
                i2c_wr_bus_pkg::ACK: begin
                    // slave holds sda low through the high quarters
                    if (tick && (phase_q == i2c_wr_bus_pkg::Q2) && sda_i) begin
                        missed_ack_o <= 1'b1;
                    end
                    if (bit_end) begin
                        if (!data_byte_q) begin
                            data_byte_q <= 1'b1;
                            state_q     <= i2c_wr_bus_pkg::DATA;
                        end else if (op_q == i2c_wr_reg_pkg::OP_WRITE_STOP) begin
                            state_q <= i2c_wr_bus_pkg::STOP;
                        end else begin
                            state_q <= i2c_wr_bus_pkg::IDLE;
                        end
                    end
                end
                i2c_wr_bus_pkg::STOP: begin
                    if (bit_end) begin
                        bus_control_o <= 1'b0;
                        state_q       <= i2c_wr_bus_pkg::IDLE;
                    end
                end
                default: state_q <= i2c_wr_bus_pkg::IDLE;
            endcase
        end
    end

    // address with R/W 0 after a start, otherwise the data byte goes first
    always_ff @(posedge clk) begin
        if ((state_q == i2c_wr_bus_pkg::WAIT_DATA) && !fifo_empty_i) begin
            data_q <= fifo_data_i;
            if (start_q) begin
                shift_q <= {held_addr_q, 1'b0};
            end else begin
                shift_q <= fifo_data_i;
            end
        end else if (bit_end && ((state_q == i2c_wr_bus_pkg::ADDR) ||
                                 (state_q == i2c_wr_bus_pkg::DATA))) begin
            shift_q <= shift_q << 1;
        end else if (bit_end && (state_q == i2c_wr_bus_pkg::ACK) && !data_byte_q) begin
            shift_q <= data_q;
        end
    end

endmodule

// ==== source/i2c_wr_fifo.sv ====
/* synchronous byte FIFO from the register block to the engine
   head entry shows on pop_data_o whenever not empty */
`include "i2c_wr_defs.svh"

module i2c_wr_fifo #(
    parameter int DEPTH = `I2C_WR_FIFO_DEPTH
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          push_i,
    input  logic [`I2C_WR_DATA_W-1:0]     push_data_i,
    input  logic                          pop_i,
    output logic [`I2C_WR_DATA_W-1:0]     pop_data_o,
    output logic                          empty_o,
    output logic                          full_o
);

    localparam int AW = $clog2(DEPTH);

    logic [`I2C_WR_DATA_W-1:0] mem_q [DEPTH];
    // extra msb tells full from empty
    logic [AW:0]               wptr_q;
    logic [AW:0]               rptr_q;

    assign empty_o    = (wptr_q == rptr_q);
    assign full_o     = (wptr_q[AW] != rptr_q[AW]) && (wptr_q[AW-1:0] == rptr_q[AW-1:0]);
    assign pop_data_o = mem_q[rptr_q[AW-1:0]];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wptr_q <= '0;
            rptr_q <= '0;
        end else begin
            // push when full and pop when empty are dropped
            if (push_i && !full_o) begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (pop_i && !empty_o) begin
                rptr_q <= rptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i && !full_o) begin
            mem_q[wptr_q[AW-1:0]] <= push_data_i;
        end
    end

endmodule

// ==== source/i2c_wr_reg_pkg.sv ====
/* register-side types: word offsets of the strobe bus
   and the opcode handed from the register block to the engine */
`include "i2c_wr_defs.svh"

package i2c_wr_reg_pkg;

    // word offsets, byte offsets are 4x
    typedef enum logic [`I2C_WR_REG_AW-1:0] {
        STATUS   = 2'd0,
        COMMAND  = 2'd1,
        DATA     = 2'd2,
        PRESCALE = 2'd3
    } reg_addr_e;

    // engine opcodes
    typedef enum logic [1:0] {
        OP_NONE       = 2'd0,
        OP_WRITE      = 2'd1,  // byte, bus stays held
        OP_WRITE_STOP = 2'd2,  // byte, then stop
        OP_STOP       = 2'd3
    } cmd_op_e;

endpackage

// ==== source/i2c_wr_regs.sv ====
/* register block on the single-cycle strobe bus
   holds prescale, command fields and sticky flags, launches engine commands */
`include "i2c_wr_defs.svh"

module i2c_wr_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_en_i,
    input  logic                          rd_en_i,
    input  i2c_wr_reg_pkg::reg_addr_e     addr_i,
    input  logic [31:0]                   wdata_i,
    input  logic [1:0]                    be_i,
    input  logic                          fifo_empty_i,
    input  logic                          fifo_full_i,
    input  logic                          busy_i,
    input  logic                          bus_control_i,
    input  logic                          missed_ack_i,
    output logic [31:0]                   rdata_o,
    output logic                          push_o,
    output logic [`I2C_WR_DATA_W-1:0]     push_data_o,
    output logic                          cmd_valid_o,
    output i2c_wr_reg_pkg::cmd_op_e       cmd_op_o,
    output logic [`I2C_WR_ADDR_W-1:0]     cmd_addr_o,
    output logic                          cmd_start_o,
    output logic [15:0]                   prescale_o
);

    logic        cmd_write_q;
    logic        cmd_stop_q;
    logic        miss_ack_q;
    logic        cmd_ovf_q;
    logic        wr_ovf_q;
    logic        eng_busy;
    logic        st_wr;
    logic        launch;
    logic [31:0] status_word;
    logic [31:0] cmd_word;

    // a launched command counts as busy until the engine raises busy
    assign eng_busy = busy_i | cmd_valid_o;
    assign st_wr    = wr_en_i && (addr_i == i2c_wr_reg_pkg::STATUS);
    // command bits live in byte 1
    assign launch   = wr_en_i && (addr_i == i2c_wr_reg_pkg::COMMAND) && be_i[1] &&
                      (wdata_i[`I2C_WR_CMD_WRITE] || wdata_i[`I2C_WR_CMD_STOP]);

    // data write pushes straight into the FIFO
    assign push_o      = wr_en_i && (addr_i == i2c_wr_reg_pkg::DATA) && be_i[0];
    assign push_data_o = wdata_i[`I2C_WR_DATA_W-1:0];

    // opcode from the stored command bits
    always_comb begin
        if (cmd_write_q && cmd_stop_q) begin
            cmd_op_o = i2c_wr_reg_pkg::OP_WRITE_STOP;
        end else if (cmd_write_q) begin
            cmd_op_o = i2c_wr_reg_pkg::OP_WRITE;
        end else if (cmd_stop_q) begin
            cmd_op_o = i2c_wr_reg_pkg::OP_STOP;
        end else begin
            cmd_op_o = i2c_wr_reg_pkg::OP_NONE;
        end
    end

    always_comb begin
        status_word = '0;
        status_word[`I2C_WR_ST_BUSY]     = eng_busy;
        status_word[`I2C_WR_ST_BUS_CONT] = bus_control_i;
        status_word[`I2C_WR_ST_MISS_ACK] = miss_ack_q;
        status_word[`I2C_WR_ST_CMD_OVF]  = cmd_ovf_q;
        status_word[`I2C_WR_ST_WR_EMPTY] = fifo_empty_i;
        status_word[`I2C_WR_ST_WR_FULL]  = fifo_full_i;
        status_word[`I2C_WR_ST_WR_OVF]   = wr_ovf_q;
        cmd_word = '0;
        cmd_word[`I2C_WR_ADDR_W-1:0]  = cmd_addr_o;
        cmd_word[`I2C_WR_CMD_START]   = cmd_start_o;
        cmd_word[`I2C_WR_CMD_WRITE]   = cmd_write_q;
        cmd_word[`I2C_WR_CMD_STOP]    = cmd_stop_q;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prescale_o  <= 16'(`I2C_WR_DEFAULT_PRESCALE);
            cmd_addr_o  <= '0;
            cmd_start_o <= 1'b0;
            cmd_write_q <= 1'b0;
            cmd_stop_q  <= 1'b0;
            cmd_valid_o <= 1'b0;
            miss_ack_q  <= 1'b0;
            cmd_ovf_q   <= 1'b0;
            wr_ovf_q    <= 1'b0;
        end else begin
            cmd_valid_o <= launch && !eng_busy;
            // sticky flags, a new event wins over write-1-to-clear
            if (missed_ack_i) begin
                miss_ack_q <= 1'b1;
            end else if (st_wr && be_i[0] && wdata_i[`I2C_WR_ST_MISS_ACK]) begin
                miss_ack_q <= 1'b0;
            end
            if (launch && eng_busy) begin
                cmd_ovf_q <= 1'b1;
            end else if (st_wr && be_i[1] && wdata_i[`I2C_WR_ST_CMD_OVF]) begin
                cmd_ovf_q <= 1'b0;
            end
            if (push_o && fifo_full_i) begin
                wr_ovf_q <= 1'b1;
            end else if (st_wr && be_i[1] && wdata_i[`I2C_WR_ST_WR_OVF]) begin
                wr_ovf_q <= 1'b0;
            end
            if (wr_en_i && (addr_i == i2c_wr_reg_pkg::COMMAND)) begin
                if (be_i[0]) begin
                    cmd_addr_o <= wdata_i[`I2C_WR_ADDR_W-1:0];
                end
                if (be_i[1]) begin
                    cmd_start_o <= wdata_i[`I2C_WR_CMD_START];
                    cmd_write_q <= wdata_i[`I2C_WR_CMD_WRITE];
                    cmd_stop_q  <= wdata_i[`I2C_WR_CMD_STOP];
                end
            end
            if (wr_en_i && (addr_i == i2c_wr_reg_pkg::PRESCALE)) begin
                if (be_i[0]) begin
                    prescale_o[7:0] <= wdata_i[7:0];
                end
                if (be_i[1]) begin
                    prescale_o[15:8] <= wdata_i[15:8];
                end
            end
        end
    end

    // read data held until the next read, DATA has no read path
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            case (addr_i)
                i2c_wr_reg_pkg::STATUS:   rdata_o <= status_word;
                i2c_wr_reg_pkg::COMMAND:  rdata_o <= cmd_word;
                i2c_wr_reg_pkg::PRESCALE: rdata_o <= {16'd0, prescale_o};
                default:                  rdata_o <= '0;
            endcase
        end
    end

endmodule

// ==== source/i2c_wr_top.sv ====
/* write-only I2C master top level
   register block feeds the byte FIFO and the bus engine */
`include "i2c_wr_defs.svh"

module i2c_wr_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_en_i,
    input  logic                          rd_en_i,
    input  i2c_wr_reg_pkg::reg_addr_e     addr_i,
    input  logic [31:0]                   wdata_i,
    input  logic [1:0]                    be_i,
    input  logic                          sda_i,
    output logic [31:0]                   rdata_o,
    output logic                          scl_o,
    output logic                          sda_o
);

    logic                          push;
    logic [`I2C_WR_DATA_W-1:0]     push_data;
    logic                          pop;
    logic [`I2C_WR_DATA_W-1:0]     pop_data;
    logic                          empty;
    logic                          full;
    logic                          cmd_valid;
    i2c_wr_reg_pkg::cmd_op_e       cmd_op;
    logic [`I2C_WR_ADDR_W-1:0]     cmd_addr;
    logic                          cmd_start;
    logic [15:0]                   prescale;
    logic                          busy;
    logic                          bus_control;
    logic                          missed_ack;

    i2c_wr_regs u_regs (
        .clk(clk), .rst(rst), .wr_en_i(wr_en_i), .rd_en_i(rd_en_i), .addr_i(addr_i),
        .wdata_i(wdata_i), .be_i(be_i), .fifo_empty_i(empty), .fifo_full_i(full),
        .busy_i(busy), .bus_control_i(bus_control), .missed_ack_i(missed_ack),
        .rdata_o(rdata_o), .push_o(push), .push_data_o(push_data),
        .cmd_valid_o(cmd_valid), .cmd_op_o(cmd_op), .cmd_addr_o(cmd_addr),
        .cmd_start_o(cmd_start), .prescale_o(prescale)
    );

    i2c_wr_fifo #(.DEPTH(`I2C_WR_FIFO_DEPTH)) u_fifo (
        .clk(clk), .rst(rst), .push_i(push), .push_data_i(push_data), .pop_i(pop),
        .pop_data_o(pop_data), .empty_o(empty), .full_o(full)
    );

    i2c_wr_engine u_engine (
        .clk(clk), .rst(rst), .cmd_valid_i(cmd_valid), .cmd_op_i(cmd_op),
        .cmd_addr_i(cmd_addr), .cmd_start_i(cmd_start), .prescale_i(prescale),
        .fifo_empty_i(empty), .fifo_data_i(pop_data), .sda_i(sda_i),
        .fifo_pop_o(pop), .busy_o(busy), .bus_control_o(bus_control),
        .missed_ack_o(missed_ack), .scl_o(scl_o), .sda_o(sda_o)
    );

endmodule
